// ==== verilog/decode_pkg.sv ====
package decode_pkg;

   // architectural widths
   localparam int XLEN   = 32;
   localparam int INST_W = 32;
   localparam int REG_W  = 5;
   localparam int EXC_W  = 6;

   // instruction field positions
   localparam int OPC_HI = 31;
   localparam int OPC_LO = 26;
   localparam int RK_LO  = 10;
   localparam int RJ_LO  = 5;
   localparam int RD_LO  = 0;

   // reduced opcode classes, anything unknown lands on ILLEGAL
   typedef enum logic [3:0] {
      ALU, MUL, DIV, LOAD, STORE, BEQ, BL,
      SYSCALL, BREAK, DBAR, IDLE, FADD, ILLEGAL
   } op_class_t;

   // opcode table, bits 31:26 of the instruction
   localparam logic [5:0] OPC_ALU     = 6'h01;
   localparam logic [5:0] OPC_MUL     = 6'h02;
   localparam logic [5:0] OPC_DIV     = 6'h03;
   localparam logic [5:0] OPC_LOAD    = 6'h04;
   localparam logic [5:0] OPC_STORE   = 6'h05;
   localparam logic [5:0] OPC_BEQ     = 6'h06;
   localparam logic [5:0] OPC_BL      = 6'h07;
   localparam logic [5:0] OPC_SYSCALL = 6'h08;
   localparam logic [5:0] OPC_BREAK   = 6'h09;
   localparam logic [5:0] OPC_DBAR    = 6'h0a;
   localparam logic [5:0] OPC_IDLE    = 6'h0b;
   localparam logic [5:0] OPC_FADD    = 6'h0c;

   // exception codes
   localparam logic [EXC_W-1:0] EXC_INT = 6'd0;
   localparam logic [EXC_W-1:0] EXC_SYS = 6'd11;
   localparam logic [EXC_W-1:0] EXC_BRK = 6'd12;
   localparam logic [EXC_W-1:0] EXC_INE = 6'd13;
   localparam logic [EXC_W-1:0] EXC_FPD = 6'd15;

   // bl writes its return address here
   localparam logic [REG_W-1:0] RF_LINK = 5'd1;

   // decoded result of one slot
   typedef struct packed {
      op_class_t        op_class;
      logic             rj_read;
      logic             rk_read;
      logic             rd_read;
      logic             rf_wen;
      logic [REG_W-1:0] rf_target;
   } dec_op_t;

   // barrier fsm states
   typedef enum logic [1:0] {
      BAR_IDLE, BAR_STRONG, BAR_WAIT
   } barrier_state_t;

endpackage

// ==== verilog/slot_if.sv ====
`timescale 1ns/1ns

interface slot_if
   import decode_pkg::*;
();

   // one decoded slot as seen after the decoder
   logic              valid;
   logic [XLEN-1:0]   pc;
   logic [INST_W-1:0] inst;
   dec_op_t           op;
   // resolved exception after priority
   logic              exception;
   logic [EXC_W-1:0]  exccode;

   // decoder side drives everything
   modport dec (
      output valid, pc, inst, op, exception, exccode
   );

   // pair checker and issue registers only read
   modport sink (
      input valid, pc, inst, op, exception, exccode
   );

endinterface

// ==== verilog/slot_decoder.sv ====
`timescale 1ns/1ns

module slot_decoder
   import decode_pkg::*;
(
   input  logic [INST_W-1:0] inst,
   input  logic [XLEN-1:0]   pc,
   input  logic              valid,
   input  logic              fetch_exception,
   input  logic [EXC_W-1:0]  fetch_exccode,
   input  logic              int_except,
   input  logic              fpu_enable,
   slot_if.dec               s
);

   op_class_t        cls;
   dec_op_t          op;
   logic [REG_W-1:0] rd;
   logic             fpd;
   logic             exc;
   logic [EXC_W-1:0] code;

   assign rd = inst[RD_LO +: REG_W];

   // opcode table lookup
   always_comb
   begin
      case (inst[OPC_HI:OPC_LO])
         OPC_ALU:     cls = ALU;
         OPC_MUL:     cls = MUL;
         OPC_DIV:     cls = DIV;
         OPC_LOAD:    cls = LOAD;
         OPC_STORE:   cls = STORE;
         OPC_BEQ:     cls = BEQ;
         OPC_BL:      cls = BL;
         OPC_SYSCALL: cls = SYSCALL;
         OPC_BREAK:   cls = BREAK;
         OPC_DBAR:    cls = DBAR;
         OPC_IDLE:    cls = IDLE;
         OPC_FADD:    cls = FADD;
         default:     cls = ILLEGAL;
      endcase
   end

   // register read and write rules per class
   always_comb
   begin
      op.op_class = cls;
      op.rj_read  = cls inside {ALU, MUL, DIV, LOAD, STORE, BEQ};
      op.rk_read  = cls inside {ALU, MUL, DIV};
      // store data and branch compare come in on rd
      op.rd_read  = cls inside {STORE, BEQ};
      op.rf_wen   = cls inside {ALU, MUL, DIV, LOAD, BL};
      // bl links to r1, target stays zero without a write
      if (cls == BL)
         op.rf_target = RF_LINK;
      else if (op.rf_wen)
         op.rf_target = rd;
      else
         op.rf_target = '0;
   end

   // float op while the fpu is switched off
   assign fpd = (cls == FADD) && !fpu_enable;

   // fixed exception priority, interrupt first
   always_comb
   begin
      exc = 1'b1;
      if (int_except)
         code = EXC_INT;
      else if (fetch_exception)
         code = fetch_exccode;
      else if (cls == SYSCALL)
         code = EXC_SYS;
      else if (cls == BREAK)
         code = EXC_BRK;
      else if (cls == ILLEGAL)
         code = EXC_INE;
      else if (fpd)
         code = EXC_FPD;
      else
      begin
         exc  = 1'b0;
         code = '0;
      end
   end

   assign s.valid     = valid;
   assign s.pc        = pc;
   assign s.inst      = inst;
   assign s.op        = op;
   assign s.exception = exc;
   assign s.exccode   = code;

endmodule

// ==== verilog/pair_check.sv ====
`timescale 1ns/1ns

module pair_check
   import decode_pkg::*;
(
   slot_if.sink s0,
   slot_if.sink s1,
   output logic pair_ok
);

   logic [REG_W-1:0] rj1;
   logic [REG_W-1:0] rk1;
   logic [REG_W-1:0] rd1;
   logic [REG_W-1:0] w0;
   logic             data_hazard;
   logic             unit_conflict;
   logic             single_issue;
   op_class_t        c0;
   op_class_t        c1;

   assign c0 = s0.op.op_class;
   assign c1 = s1.op.op_class;

   // source registers of the younger slot
   assign rj1 = s1.inst[RJ_LO +: REG_W];
   assign rk1 = s1.inst[RK_LO +: REG_W];
   assign rd1 = s1.inst[RD_LO +: REG_W];

   // target is already zero when slot 0 does not write
   assign w0 = s0.op.rf_target;

   // raw between the two slots, r0 never counts
   assign data_hazard = s0.op.rf_wen && (w0 != '0) &&
                        ((s1.op.rj_read && (rj1 == w0)) ||
                         (s1.op.rk_read && (rk1 == w0)) ||
                         (s1.op.rd_read && (rd1 == w0)));

   // one multiplier/divider, one lsu, one branch unit
   assign unit_conflict = ((c0 inside {MUL, DIV})   && (c1 inside {MUL, DIV}))   ||
                          ((c0 inside {LOAD, STORE}) && (c1 inside {LOAD, STORE})) ||
                          ((c0 inside {BEQ, BL})     && (c1 inside {BEQ, BL}));

   // these always go down the pipe alone
   assign single_issue = s0.exception || s1.exception ||
                         (c0 inside {DIV, DBAR, IDLE}) ||
                         (c1 inside {DIV, DBAR, IDLE});

   assign pair_ok = s0.valid && s1.valid &&
                    !data_hazard && !unit_conflict && !single_issue;

endmodule

// ==== verilog/barrier_ctrl.sv ====
`timescale 1ns/1ns

module barrier_ctrl
   import decode_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      flush,
   input  logic      int_except,
   input  logic      take,
   input  op_class_t s0_class,
   input  logic      mshr_empty,
   input  logic      pipe_busy,
   output logic      idle
);

   barrier_state_t state;

   always_ff @(posedge clk)
   begin
      // flush wins over any pending barrier
      if (rst || flush)
         state <= BAR_IDLE;
      else
      begin
         case (state)
            BAR_IDLE:
            begin
               // only slot 0 can hold a barrier, pairing keeps it alone
               if (take && (s0_class == DBAR))
                  state <= BAR_STRONG;
               else if (take && (s0_class == IDLE))
                  state <= BAR_WAIT;
            end
            BAR_STRONG:
            begin
               // wait for outstanding misses and an empty back end
               if (mshr_empty && !pipe_busy)
                  state <= BAR_IDLE;
            end
            BAR_WAIT:
            begin
               // idle sleeps until an interrupt arrives
               if (int_except)
                  state <= BAR_IDLE;
            end
            default:
               state <= BAR_IDLE;
         endcase
      end
   end

   assign idle = (state == BAR_IDLE);

endmodule

// ==== verilog/issue_regs.sv ====
`timescale 1ns/1ns

module issue_regs
   import decode_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              take,
   input  logic              flush,
   input  logic              pair_ok,
   input  logic              bar_idle,
   slot_if.sink              s0,
   slot_if.sink              s1,
   output logic              is_slot0_valid,
   output logic              is_slot1_valid,
   output logic [XLEN-1:0]   is_slot0_pc,
   output logic [INST_W-1:0] is_slot0_inst,
   output dec_op_t           is_slot0_op,
   output logic              is_slot0_exception,
   output logic [EXC_W-1:0]  is_slot0_exccode,
   output logic [XLEN-1:0]   is_slot1_pc,
   output logic [INST_W-1:0] is_slot1_inst,
   output dec_op_t           is_slot1_op,
   output logic              is_slot1_exception,
   output logic [EXC_W-1:0]  is_slot1_exccode
);

   logic v0;
   logic v1;

   // valid bits, a take without an offer leaves a bubble
   always_ff @(posedge clk)
   begin
      if (rst || flush)
      begin
         v0 <= 1'b0;
         v1 <= 1'b0;
      end
      else if (take)
      begin
         v0 <= s0.valid;
         v1 <= s1.valid && pair_ok;
      end
   end

   // payload, holds under back-pressure
   always_ff @(posedge clk)
   begin
      if (take)
      begin
         is_slot0_pc        <= s0.pc;
         is_slot0_inst      <= s0.inst;
         is_slot0_op        <= s0.op;
         is_slot0_exception <= s0.exception;
         is_slot0_exccode   <= s0.exccode;
      end
      // slot 1 only moves when it pairs with slot 0
      if (take && pair_ok)
      begin
         is_slot1_pc        <= s1.pc;
         is_slot1_inst      <= s1.inst;
         is_slot1_op        <= s1.op;
         is_slot1_exception <= s1.exception;
         is_slot1_exccode   <= s1.exccode;
      end
   end

   // held barrier op stays invisible until release
   assign is_slot0_valid = v0 && bar_idle;
   assign is_slot1_valid = v1 && bar_idle;

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage
   import decode_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              exception,
   input  logic              eret,
   input  logic              bru_cancel,
   input  logic              int_except,
   input  logic              fpu_enable,
   input  logic              mshr_empty,
   input  logic              pipe_busy,
   input  logic              is_allow_in,
   input  logic              de_slot0_valid,
   input  logic [XLEN-1:0]   de_slot0_pc,
   input  logic [INST_W-1:0] de_slot0_inst,
   input  logic              de_slot0_exception,
   input  logic [EXC_W-1:0]  de_slot0_exccode,
   input  logic              de_slot1_valid,
   input  logic [XLEN-1:0]   de_slot1_pc,
   input  logic [INST_W-1:0] de_slot1_inst,
   input  logic              de_slot1_exception,
   input  logic [EXC_W-1:0]  de_slot1_exccode,
   output logic              de_allow_in,
   output logic [1:0]        de_accept,
   output logic              is_slot0_valid,
   output logic              is_slot1_valid,
   output logic [XLEN-1:0]   is_slot0_pc,
   output logic [INST_W-1:0] is_slot0_inst,
   output dec_op_t           is_slot0_op,
   output logic              is_slot0_exception,
   output logic [EXC_W-1:0]  is_slot0_exccode,
   output logic [XLEN-1:0]   is_slot1_pc,
   output logic [INST_W-1:0] is_slot1_inst,
   output dec_op_t           is_slot1_op,
   output logic              is_slot1_exception,
   output logic [EXC_W-1:0]  is_slot1_exccode
);

   slot_if s0 ();
   slot_if s1 ();

   logic flush;
   logic pair_ok;
   logic bar_idle;
   logic bar_take;

   // any redirect from the back end empties the stage
   assign flush       = exception || eret || bru_cancel;
   assign de_allow_in = bar_idle && (is_allow_in || flush);
   // bit 1 tells fetch whether slot 1 went along
   assign de_accept   = {de_allow_in && pair_ok, de_allow_in};
   // barrier only arms on a real slot 0 instruction
   assign bar_take    = de_allow_in && s0.valid;

   slot_decoder slot0_dec_i (
      .inst(de_slot0_inst), .pc(de_slot0_pc), .valid(de_slot0_valid),
      .fetch_exception(de_slot0_exception), .fetch_exccode(de_slot0_exccode),
      .int_except(int_except), .fpu_enable(fpu_enable), .s(s0)
   );

   // interrupts are taken on the oldest slot only
   slot_decoder slot1_dec_i (
      .inst(de_slot1_inst), .pc(de_slot1_pc), .valid(de_slot1_valid),
      .fetch_exception(de_slot1_exception), .fetch_exccode(de_slot1_exccode),
      .int_except(1'b0), .fpu_enable(fpu_enable), .s(s1)
   );

   pair_check pair_i (.s0(s0), .s1(s1), .pair_ok(pair_ok));

   barrier_ctrl barrier_i (
      .clk(clk), .rst(rst), .flush(flush), .int_except(int_except),
      .take(bar_take), .s0_class(s0.op.op_class),
      .mshr_empty(mshr_empty), .pipe_busy(pipe_busy), .idle(bar_idle)
   );

   issue_regs regs_i (
      .clk(clk), .rst(rst), .take(de_allow_in), .flush(flush),
      .pair_ok(pair_ok), .bar_idle(bar_idle), .s0(s0), .s1(s1),
      .is_slot0_valid(is_slot0_valid), .is_slot1_valid(is_slot1_valid),
      .is_slot0_pc(is_slot0_pc), .is_slot0_inst(is_slot0_inst),
      .is_slot0_op(is_slot0_op), .is_slot0_exception(is_slot0_exception),
      .is_slot0_exccode(is_slot0_exccode),
      .is_slot1_pc(is_slot1_pc), .is_slot1_inst(is_slot1_inst),
      .is_slot1_op(is_slot1_op), .is_slot1_exception(is_slot1_exception),
      .is_slot1_exccode(is_slot1_exccode)
   );

endmodule

// ==== tb/decode_stage_assertions.sv ====
`timescale 1ns/1ns

module decode_stage_assertions (
   input logic clk,
   input logic rst,
   input logic flush,
   input logic bar_idle,
   input logic is_slot0_valid,
   input logic is_slot1_valid
);

   // nothing leaves the stage right after reset
   assert property (@(posedge clk) rst |=> (!is_slot0_valid && !is_slot1_valid))
      else $error("issue valid set after reset");

   // slot 1 only ever travels together with slot 0
   assert property (@(posedge clk) disable iff (rst) is_slot1_valid |-> is_slot0_valid)
      else $error("slot 1 valid without slot 0");

   // flush drops any pending barrier
   assert property (@(posedge clk) disable iff (rst) flush |=> bar_idle)
      else $error("barrier not idle after flush");

endmodule

bind issue_regs decode_stage_assertions assert_i (
   .clk(clk),
   .rst(rst),
   .flush(flush),
   .bar_idle(bar_idle),
   .is_slot0_valid(is_slot0_valid),
   .is_slot1_valid(is_slot1_valid)
);

// ==== tb/decode_stage_tb.sv ====
`timescale 1ns/1ns

module decode_stage_tb
   import decode_pkg::*;
();

   // expected view of one decoded slot
   typedef struct packed {
      dec_op_t          op;
      logic             exc;
      logic [EXC_W-1:0] code;
   } exp_slot_t;

   // opcode table in class order with an unused opcode as the last entry
   localparam logic [5:0] OPC_TAB [13] = '{
      OPC_ALU, OPC_MUL, OPC_DIV, OPC_LOAD, OPC_STORE, OPC_BEQ, OPC_BL,
      OPC_SYSCALL, OPC_BREAK, OPC_DBAR, OPC_IDLE, OPC_FADD, 6'h3f
   };

   logic              clk;
   logic              rst;
   logic              exception;
   logic              eret;
   logic              bru_cancel;
   logic              int_except;
   logic              fpu_enable;
   logic              mshr_empty;
   logic              pipe_busy;
   logic              is_allow_in;
   logic              de_slot0_valid;
   logic [XLEN-1:0]   de_slot0_pc;
   logic [INST_W-1:0] de_slot0_inst;
   logic              de_slot0_exception;
   logic [EXC_W-1:0]  de_slot0_exccode;
   logic              de_slot1_valid;
   logic [XLEN-1:0]   de_slot1_pc;
   logic [INST_W-1:0] de_slot1_inst;
   logic              de_slot1_exception;
   logic [EXC_W-1:0]  de_slot1_exccode;
   logic              de_allow_in;
   logic [1:0]        de_accept;
   logic              is_slot0_valid;
   logic              is_slot1_valid;
   logic [XLEN-1:0]   is_slot0_pc;
   logic [INST_W-1:0] is_slot0_inst;
   dec_op_t           is_slot0_op;
   logic              is_slot0_exception;
   logic [EXC_W-1:0]  is_slot0_exccode;
   logic [XLEN-1:0]   is_slot1_pc;
   logic [INST_W-1:0] is_slot1_inst;
   dec_op_t           is_slot1_op;
   logic              is_slot1_exception;
   logic [EXC_W-1:0]  is_slot1_exccode;

   int                seed;
   logic [XLEN-1:0]   pc_cnt;
   logic [XLEN-1:0]   held_pc;
   // expectation handed from stimulus to the compare process
   logic              pending;
   string             exp_name;
   logic              exp_v0;
   logic              exp_pair;
   exp_slot_t         exp0;
   exp_slot_t         exp1;
   logic [XLEN-1:0]   exp_pc;
   logic [INST_W-1:0] exp_inst0;
   logic [INST_W-1:0] exp_inst1;
   // copies taken by the compare process at the take edge
   string             cmp_name;
   logic              cmp_v0;
   logic              cmp_pair;
   exp_slot_t         cmp0;
   exp_slot_t         cmp1;
   logic [XLEN-1:0]   cmp_pc;
   logic [INST_W-1:0] cmp_inst0;
   logic [INST_W-1:0] cmp_inst1;

   decode_stage dut_i (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // hard limit on the whole run
   initial
   begin
      #2000000;
      $display("simulation timed out");
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

   task automatic fail_plain(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_op(input string name, input dec_op_t e, input dec_op_t a);
      if (a !== e)
      begin
         $display("ERROR %s: expected %h actual %h", name, e, a);
         $display("TEST FAILED");
         $fatal(1, "decoded op mismatch");
      end
   endtask

   task automatic check_exc(input string name, input logic [EXC_W-1:0] e,
                            input logic [EXC_W-1:0] a);
      if (a !== e)
      begin
         $display("ERROR %s: expected %0d actual %0d", name, e, a);
         $display("TEST FAILED");
         $fatal(1, "exception code mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic e, input logic a);
      if (a !== e)
      begin
         $display("ERROR %s: expected %b actual %b", name, e, a);
         $display("TEST FAILED");
         $fatal(1, "bit mismatch");
      end
   endtask

   task automatic check_word(input string name, input logic [XLEN-1:0] e,
                             input logic [XLEN-1:0] a);
      if (a !== e)
      begin
         $display("ERROR %s: expected %h actual %h", name, e, a);
         $display("TEST FAILED");
         $fatal(1, "word mismatch");
      end
   endtask

   // reference decode straight from the opcode table and priority list
   function automatic exp_slot_t ref_slot(input logic [31:0] inst, input logic fexc,
                                          input logic [EXC_W-1:0] fcode, input logic intr,
                                          input logic fpu);
      exp_slot_t r;
      op_class_t c;
      case (inst[OPC_HI:OPC_LO])
         OPC_ALU:     c = ALU;
         OPC_MUL:     c = MUL;
         OPC_DIV:     c = DIV;
         OPC_LOAD:    c = LOAD;
         OPC_STORE:   c = STORE;
         OPC_BEQ:     c = BEQ;
         OPC_BL:      c = BL;
         OPC_SYSCALL: c = SYSCALL;
         OPC_BREAK:   c = BREAK;
         OPC_DBAR:    c = DBAR;
         OPC_IDLE:    c = IDLE;
         OPC_FADD:    c = FADD;
         default:     c = ILLEGAL;
      endcase
      r.op.op_class = c;
      r.op.rj_read  = (c == ALU) || (c == MUL) || (c == DIV) || (c == LOAD) ||
                      (c == STORE) || (c == BEQ);
      r.op.rk_read  = (c == ALU) || (c == MUL) || (c == DIV);
      r.op.rd_read  = (c == STORE) || (c == BEQ);
      r.op.rf_wen   = (c == ALU) || (c == MUL) || (c == DIV) || (c == LOAD) || (c == BL);
      if (!r.op.rf_wen)
         r.op.rf_target = '0;
      else if (c == BL)
         r.op.rf_target = RF_LINK;
      else
         r.op.rf_target = inst[4:0];
      r.exc = 1'b1;
      if (intr)
         r.code = EXC_INT;
      else if (fexc)
         r.code = fcode;
      else if (c == SYSCALL)
         r.code = EXC_SYS;
      else if (c == BREAK)
         r.code = EXC_BRK;
      else if (c == ILLEGAL)
         r.code = EXC_INE;
      else if ((c == FADD) && !fpu)
         r.code = EXC_FPD;
      else
      begin
         r.exc  = 1'b0;
         r.code = '0;
      end
      return r;
   endfunction

   // reference pairing rule
   function automatic logic ref_pair(input logic v0, input logic v1, input logic [31:0] i1,
                                     input exp_slot_t a, input exp_slot_t b);
      logic [4:0] w;
      logic       haz;
      logic       unit;
      logic       alone;
      op_class_t  c0;
      op_class_t  c1;
      c0    = a.op.op_class;
      c1    = b.op.op_class;
      w     = a.op.rf_target;
      haz   = a.op.rf_wen && (w != 5'd0) &&
              ((b.op.rj_read && (i1[9:5] == w)) || (b.op.rk_read && (i1[14:10] == w)) ||
               (b.op.rd_read && (i1[4:0] == w)));
      unit  = ((c0 == MUL || c0 == DIV) && (c1 == MUL || c1 == DIV)) ||
              ((c0 == LOAD || c0 == STORE) && (c1 == LOAD || c1 == STORE)) ||
              ((c0 == BEQ || c0 == BL) && (c1 == BEQ || c1 == BL));
      alone = a.exc || b.exc || (c0 == DIV) || (c0 == DBAR) || (c0 == IDLE) ||
              (c1 == DIV) || (c1 == DBAR) || (c1 == IDLE);
      return v0 && v1 && !haz && !unit && !alone;
   endfunction

   // registers limited to r0..r3 so hazards come up often
   function automatic logic [31:0] make_inst(input logic [5:0] opc);
      int          r;
      logic [31:0] x;
      r          = $random(seed);
      x          = r;
      x[31:26]   = opc;
      x[14:12]   = 3'b000;
      x[9:7]     = 3'b000;
      x[4:2]     = 3'b000;
      return x;
   endfunction

   function automatic int pick_index();
      int r;
      r = $random(seed);
      if (r < 0)
         r = -r;
      return r % 13;
   endfunction

   // drive one offer and check the accept bits before handing over the expectation
   task automatic offer(input string name, input logic v0, input logic [31:0] i0,
                        input logic e0, input logic [EXC_W-1:0] c0, input logic v1,
                        input logic [31:0] i1, input logic e1, input logic [EXC_W-1:0] c1,
                        input logic intr, input logic fpu, input logic arm);
      exp_slot_t r0;
      exp_slot_t r1;
      logic      pr;
      @(posedge clk);
      de_slot0_valid     <= v0;
      de_slot0_pc        <= pc_cnt;
      de_slot0_inst      <= i0;
      de_slot0_exception <= e0;
      de_slot0_exccode   <= c0;
      de_slot1_valid     <= v1;
      de_slot1_pc        <= pc_cnt + 32'd4;
      de_slot1_inst      <= i1;
      de_slot1_exception <= e1;
      de_slot1_exccode   <= c1;
      int_except         <= intr;
      fpu_enable         <= fpu;
      @(negedge clk);
      r0 = ref_slot(i0, e0, c0, intr, fpu);
      r1 = ref_slot(i1, e1, c1, 1'b0, fpu);
      pr = ref_pair(v0, v1, i1, r0, r1);
      check_bit({name, " allow_in"}, 1'b1, de_allow_in);
      check_bit({name, " accept0"}, 1'b1, de_accept[0]);
      check_bit({name, " accept1"}, pr, de_accept[1]);
      exp_name  = name;
      exp_v0    = v0;
      exp_pair  = pr;
      exp0      = r0;
      exp1      = r1;
      exp_pc    = pc_cnt;
      exp_inst0 = i0;
      exp_inst1 = i1;
      pending   = arm;
      pc_cnt    = pc_cnt + 32'd8;
   endtask

   // compare the is_ outputs in the cycle after each armed take
   always @(posedge clk)
   begin
      if (pending)
      begin
         pending   = 1'b0;
         cmp_name  = exp_name;
         cmp_v0    = exp_v0;
         cmp_pair  = exp_pair;
         cmp0      = exp0;
         cmp1      = exp1;
         cmp_pc    = exp_pc;
         cmp_inst0 = exp_inst0;
         cmp_inst1 = exp_inst1;
         @(negedge clk);
         check_bit({cmp_name, " slot0 valid"}, cmp_v0, is_slot0_valid);
         check_bit({cmp_name, " slot1 valid"}, cmp_pair, is_slot1_valid);
         if (cmp_v0)
         begin
            check_op({cmp_name, " slot0 op"}, cmp0.op, is_slot0_op);
            check_bit({cmp_name, " slot0 exception"}, cmp0.exc, is_slot0_exception);
            check_exc({cmp_name, " slot0 exccode"}, cmp0.code, is_slot0_exccode);
            check_word({cmp_name, " slot0 pc"}, cmp_pc, is_slot0_pc);
            check_word({cmp_name, " slot0 inst"}, cmp_inst0, is_slot0_inst);
         end
         if (cmp_pair)
         begin
            check_op({cmp_name, " slot1 op"}, cmp1.op, is_slot1_op);
            check_bit({cmp_name, " slot1 exception"}, cmp1.exc, is_slot1_exception);
            check_exc({cmp_name, " slot1 exccode"}, cmp1.code, is_slot1_exccode);
            check_word({cmp_name, " slot1 pc"}, cmp_pc + 32'd4, is_slot1_pc);
            check_word({cmp_name, " slot1 inst"}, cmp_inst1, is_slot1_inst);
         end
      end
   end

   // wait for the held slot 0 to appear after a barrier release
   task automatic wait_release(input string name, input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while (!is_slot0_valid && (n < limit))
      begin
         @(negedge clk);
         n++;
      end
      if (!is_slot0_valid)
         fail_plain({name, ": held instruction never left the barrier"});
   endtask

   initial
   begin
      int          idx;
      int          r;
      logic [31:0] i0;
      logic [31:0] i1;
      exp_slot_t   held_exp;
      seed               = 49;
      pending            = 1'b0;
      pc_cnt             = 32'h0000_1000;
      rst                = 1'b1;
      exception          = 1'b0;
      eret               = 1'b0;
      bru_cancel         = 1'b0;
      int_except         = 1'b0;
      fpu_enable         = 1'b1;
      mshr_empty         = 1'b1;
      pipe_busy          = 1'b0;
      is_allow_in        = 1'b1;
      de_slot0_valid     = 1'b0;
      de_slot0_pc        = '0;
      de_slot0_inst      = '0;
      de_slot0_exception = 1'b0;
      de_slot0_exccode   = '0;
      de_slot1_valid     = 1'b0;
      de_slot1_pc        = '0;
      de_slot1_inst      = '0;
      de_slot1_exception = 1'b0;
      de_slot1_exccode   = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      // after reset allow_in follows the issue stage
      @(negedge clk);
      check_bit("reset slot0 valid", 1'b0, is_slot0_valid);
      check_bit("reset slot1 valid", 1'b0, is_slot1_valid);
      check_bit("reset allow_in", 1'b1, de_allow_in);
      @(posedge clk);
      is_allow_in <= 1'b0;
      @(negedge clk);
      check_bit("stalled allow_in", 1'b0, de_allow_in);
      @(posedge clk);
      is_allow_in <= 1'b1;

      // single slots of every class except the barriers
      for (idx = 0; idx < 13; idx++)
      begin
         if ((idx != 9) && (idx != 10))
         begin
            i0 = make_inst(OPC_TAB[idx]);
            offer("single", 1'b1, i0, 1'b0, 6'd0, 1'b0, '0, 1'b0, 6'd0, 1'b0, 1'b1, 1'b1);
            offer("single fpu off", 1'b1, i0, 1'b0, 6'd0, 1'b0, '0, 1'b0, 6'd0,
                  1'b0, 1'b0, 1'b1);
         end
      end
      // fetch exception beats syscall and interrupt beats both
      i0 = make_inst(OPC_SYSCALL);
      offer("fetch exc", 1'b1, i0, 1'b1, 6'd7, 1'b0, '0, 1'b0, 6'd0, 1'b0, 1'b1, 1'b1);
      offer("interrupt", 1'b1, i0, 1'b1, 6'd7, 1'b0, '0, 1'b0, 6'd0, 1'b1, 1'b1, 1'b1);
      offer("int on fadd", 1'b1, make_inst(OPC_FADD), 1'b0, 6'd0, 1'b0, '0, 1'b0, 6'd0,
            1'b1, 1'b0, 1'b1);

      // random pairs where slot 0 never arms a barrier
      for (int k = 0; k < 300; k++)
      begin
         idx = pick_index();
         while ((idx == 9) || (idx == 10))
            idx = pick_index();
         i0 = make_inst(OPC_TAB[idx]);
         i1 = make_inst(OPC_TAB[pick_index()]);
         r  = $random(seed);
         offer("random pair", 1'b1, i0, (r[3:0] == 4'd0), r[9:4], r[10] || r[11], i1,
               (r[15:12] == 4'd0), r[21:16], 1'b0, r[22] || r[23], 1'b1);
      end

      // back-pressure holds the registers
      offer("hold", 1'b1, make_inst(OPC_ALU), 1'b0, 6'd0, 1'b1, make_inst(OPC_LOAD),
            1'b0, 6'd0, 1'b0, 1'b1, 1'b1);
      held_pc = pc_cnt - 32'd8;
      @(posedge clk);
      is_allow_in <= 1'b0;
      de_slot0_pc <= 32'hdead_0000;
      repeat (3)
      begin
         @(negedge clk);
         check_bit("hold allow_in", 1'b0, de_allow_in);
         check_bit("hold slot0 valid", 1'b1, is_slot0_valid);
         check_word("hold slot0 pc", held_pc, is_slot0_pc);
      end
      // flush clears the valids at the next edge
      @(posedge clk);
      exception <= 1'b1;
      @(negedge clk);
      check_bit("flush allow_in", 1'b1, de_allow_in);
      @(posedge clk);
      exception      <= 1'b0;
      is_allow_in    <= 1'b1;
      de_slot0_valid <= 1'b0;
      de_slot1_valid <= 1'b0;
      @(negedge clk);
      check_bit("flush slot0 valid", 1'b0, is_slot0_valid);
      check_bit("flush slot1 valid", 1'b0, is_slot1_valid);

      // dbar waits for empty mshrs and an idle back end
      @(posedge clk);
      mshr_empty <= 1'b0;
      i0 = make_inst(OPC_DBAR);
      offer("dbar", 1'b1, i0, 1'b0, 6'd0, 1'b0, '0, 1'b0, 6'd0, 1'b0, 1'b1, 1'b0);
      @(posedge clk);
      de_slot0_valid <= 1'b0;
      repeat (3)
      begin
         @(negedge clk);
         check_bit("dbar allow_in", 1'b0, de_allow_in);
         check_bit("dbar masked", 1'b0, is_slot0_valid);
      end
      @(posedge clk);
      mshr_empty <= 1'b1;
      pipe_busy  <= 1'b1;
      repeat (2)
      begin
         @(negedge clk);
         check_bit("dbar busy masked", 1'b0, is_slot0_valid);
      end
      @(posedge clk);
      pipe_busy <= 1'b0;
      wait_release("dbar", 20);
      held_exp = ref_slot(i0, 1'b0, 6'd0, 1'b0, 1'b1);
      check_op("dbar op", held_exp.op, is_slot0_op);

      // idle sleeps until an interrupt
      i0 = make_inst(OPC_IDLE);
      offer("idle", 1'b1, i0, 1'b0, 6'd0, 1'b0, '0, 1'b0, 6'd0, 1'b0, 1'b1, 1'b0);
      @(posedge clk);
      de_slot0_valid <= 1'b0;
      repeat (4)
      begin
         @(negedge clk);
         check_bit("idle allow_in", 1'b0, de_allow_in);
         check_bit("idle masked", 1'b0, is_slot0_valid);
      end
      @(posedge clk);
      int_except <= 1'b1;
      wait_release("idle", 20);
      held_exp = ref_slot(i0, 1'b0, 6'd0, 1'b0, 1'b1);
      check_op("idle op", held_exp.op, is_slot0_op);
      @(posedge clk);
      int_except <= 1'b0;

      repeat (3) @(posedge clk);
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== sim.f ====
verilog/decode_pkg.sv
verilog/slot_if.sv
verilog/slot_decoder.sv
verilog/pair_check.sv
verilog/barrier_ctrl.sv
verilog/issue_regs.sv
verilog/decode_stage.sv
tb/decode_stage_assertions.sv
tb/decode_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if grep -q "%Error" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
